//--- build.f
rv_pkg.sv
rv_alu.sv
rv_imm_gen.sv
rv_regfile.sv
rv_decoder.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
verilator --binary --timing --assert --top-module tb_rv_core -f build.f \
    -o sim_tb_rv_core > build.log 2>&1 \
    && ./obj_dir/sim_tb_rv_core > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int RESET_CYCLES = 8;
    // Reset, alu, load, branch, jump and invalid tests
    localparam int TOTAL_INSTRS = RESET_CYCLES + 4 + 84 + 10 + 22 + 16 + 4;
    localparam int CYCLE_LIMIT  = 2 * TOTAL_INSTRS;

    logic     clk;
    logic     reset;
    instr_t   instr;
    word_t    rd_data;
    byte_en_t wr_en;
    word_t    pc;
    word_t    addr;
    word_t    wr_data;

    word_t       model_regs [REG_COUNT];
    word_t       model_pc;
    logic [31:0] lfsr;
    int          cycles;
    int          checks;
    int          errors;
    int          tests;

    rv_core u_dut (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .pc      (pc),
        .addr    (addr),
        .wr_data (wr_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t sext12(input word_t v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // Instruction encoders
    function automatic instr_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {f7, reg_addr_t'(rs2), reg_addr_t'(rs1), f3, reg_addr_t'(rd), 7'b0110011};
    endfunction

    function automatic instr_t enc_i(input word_t imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] opc);
        return {imm[11:0], reg_addr_t'(rs1), f3, reg_addr_t'(rd), opc};
    endfunction

    function automatic instr_t enc_s(input word_t off, input int rs2, input int rs1);
        return {off[11:5], reg_addr_t'(rs2), reg_addr_t'(rs1), 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic instr_t enc_b(input word_t off, input int rs2, input int rs1,
                                     input logic [2:0] f3);
        return {off[12], off[10:5], reg_addr_t'(rs2), reg_addr_t'(rs1), f3, off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic instr_t enc_u(input word_t value, input int rd, input logic [6:0] opc);
        return {value[31:12], reg_addr_t'(rd), opc};
    endfunction

    function automatic instr_t enc_j(input word_t off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], reg_addr_t'(rd), 7'b1101111};
    endfunction

    // RV32I arithmetic rules where alt is funct7 bit 5
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return word_t'($signed(a) < $signed(b));
            3'd3: return word_t'(a < b);
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // One instruction per cycle with pc checked against the model
    task automatic exec(input instr_t i, input word_t mem_word);
        @(posedge clk);
        #1;
        instr   = i;
        rd_data = mem_word;
        #1;
        check("pc", model_pc, pc);
    endtask

    // rd of zero means no register is expected to change
    task automatic exec_write(input instr_t i, input int rd, input word_t value);
        exec(i, '0);
        check("wr_en", '0, word_t'(wr_en));
        if (rd != 0) begin
            model_regs[rd] = value;
        end
        model_pc = model_pc + PC_STEP;
    endtask

    task automatic exec_sw(input int rs2, input int rs1, input word_t off);
        exec(enc_s(off, rs2, rs1), '0);
        check("wr_en", word_t'(BYTE_EN_WORD), word_t'(wr_en));
        check("addr", (model_regs[rs1] + sext12(off)) & ~32'h3, addr);
        check("wr_data", model_regs[rs2], wr_data);
        model_pc = model_pc + PC_STEP;
    endtask

    task automatic exec_lw(input int rd, input int rs1, input word_t off, input word_t word);
        exec(enc_i(off, rs1, 3'b010, rd, LOAD), word);
        check("wr_en", '0, word_t'(wr_en));
        check("addr", (model_regs[rs1] + sext12(off)) & ~32'h3, addr);
        if (rd != 0) begin
            model_regs[rd] = word;
        end
        model_pc = model_pc + PC_STEP;
    endtask

    task automatic exec_branch(input logic [2:0] f3, input int rs1, input int rs2,
                               input word_t off);
        exec(enc_b(off, rs2, rs1, f3), '0);
        check("wr_en", '0, word_t'(wr_en));
        if (branch_model(f3, model_regs[rs1], model_regs[rs2])) begin
            model_pc = model_pc + {{19{off[12]}}, off[12:0]};
        end else begin
            model_pc = model_pc + PC_STEP;
        end
    endtask

    task automatic exec_jump(input instr_t i, input int rd, input word_t target);
        exec(i, '0);
        check("wr_en", '0, word_t'(wr_en));
        model_regs[rd] = model_pc + PC_STEP;
        model_pc = target;
    endtask

    // LUI of the rounded upper part followed by ADDI of the low 12 bits
    task automatic load_const(input int rd, input word_t value);
        word_t hi;
        hi = value + 32'h800;
        exec_write(enc_u(hi, rd, LUI), rd, {hi[31:12], 12'b0});
        exec_write(enc_i(value, rd, 3'b000, rd, OP_IMM), rd, value);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        // A store held through reset must not reach the memory port
        instr = enc_s('0, 0, 0);
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check("pc", '0, pc);
            check("wr_en", '0, word_t'(wr_en));
        end
        // First cycle out of reset runs the all-zero word as an unknown opcode
        reset = 1'b0;
        instr = '0;
        #1;
        check("pc", '0, pc);
        check("wr_en", '0, word_t'(wr_en));
        model_pc = PC_STEP;
        repeat (3) begin
            exec_write(32'h0, 0, '0);
        end
        report("reset", e0);
    endtask

    task automatic test_alu();
        int         e0;
        logic [2:0] f3;
        word_t      imm;
        e0 = errors;
        for (int round = 0; round < 2; round++) begin
            load_const(1, rand_bits(32));
            load_const(2, rand_bits(32));
            // k 8 and 9 are SUB and SRA
            for (int k = 0; k < 10; k++) begin
                f3 = (k == 8) ? 3'd0 : (k == 9) ? 3'd5 : 3'(k);
                exec_write(enc_r((k >= 8) ? 7'b0100000 : 7'b0000000, 2, 1, f3, 3), 3,
                           alu_model(f3, k >= 8, model_regs[1], model_regs[2]));
                exec_sw(3, 1, rand_bits(12));
            end
            // k 8 is SRAI
            for (int k = 0; k < 9; k++) begin
                f3 = (k == 8) ? 3'd5 : 3'(k);
                imm = rand_bits(12);
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {20'b0, (k == 8) ? 7'b0100000 : 7'b0000000, imm[4:0]};
                end
                exec_write(enc_i(imm, 1, f3, 4, OP_IMM), 4,
                           alu_model(f3, k == 8, model_regs[1], sext12(imm)));
                exec_sw(4, 2, rand_bits(12));
            end
        end
        report("alu", e0);
    endtask

    task automatic test_load();
        int e0;
        e0 = errors;
        load_const(1, rand_bits(32));
        for (int k = 0; k < 2; k++) begin
            exec_lw(5, 1, rand_bits(12), rand_bits(32));
            exec_sw(5, 0, rand_bits(12));
        end
        // Writes aimed at x0
        exec_write(enc_i(rand_bits(12), 1, 3'b000, 0, OP_IMM), 0, '0);
        exec_lw(0, 1, rand_bits(12), rand_bits(32));
        exec_write(enc_u(rand_bits(32), 0, LUI), 0, '0);
        exec_sw(0, 1, rand_bits(12));
        report("load", e0);
    endtask

    task automatic test_branch();
        int         e0;
        logic [2:0] f3;
        e0 = errors;
        load_const(6, rand_bits(32));
        load_const(7, rand_bits(32));
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            exec_branch(f3, 6, 6, rand_bits(11) << 2);
            exec_branch(f3, 6, 7, rand_bits(11) << 2);
            exec_branch(f3, 7, 6, rand_bits(11) << 2);
        end
        report("branch", e0);
    endtask

    task automatic test_jump();
        int    e0;
        word_t off;
        word_t imm;
        e0 = errors;
        for (int k = 0; k < 2; k++) begin
            off = rand_bits(19) << 2;
            exec_jump(enc_j(off, 8), 8, model_pc + {{11{off[20]}}, off[20:0]});
            exec_sw(8, 0, rand_bits(12));
            // Odd offset on an aligned base leaves bit 0 of the target to be cleared
            load_const(1, rand_bits(32) & ~32'h3);
            off = (rand_bits(10) << 2) | 32'h1;
            exec_jump(enc_i(off, 1, 3'b000, 9, JALR), 9,
                      (model_regs[1] + sext12(off)) & ~32'h1);
            exec_sw(9, 0, rand_bits(12));
            imm = rand_bits(32);
            exec_write(enc_u(imm, 10, AUIPC), 10, model_pc + {imm[31:12], 12'b0});
            exec_sw(10, 0, rand_bits(12));
        end
        report("jump", e0);
    endtask

    task automatic test_invalid();
        int e0;
        e0 = errors;
        exec_write(enc_u(rand_bits(32), 3, 7'b1111111), 0, '0);
        exec_write(enc_r(7'b0000001, 2, 1, 3'(rand_bits(3)), 1), 0, '0);
        exec_sw(3, 0, rand_bits(12));
        exec_sw(1, 0, rand_bits(12));
        report("invalid", e0);
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        instr    = '0;
        rd_data  = '0;
        model_pc = '0;
        lfsr     = 32'h1f8a_8ce3;
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        test_reset();
        test_alu();
        test_load();
        test_branch();
        test_jump();
        test_invalid();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props (
    input logic             clk,
    input logic             reset,
    input rv_pkg::byte_en_t wr_en,
    input rv_pkg::word_t    pc
);
    import rv_pkg::*;

    // Only full-word stores exist
    wr_en_word: assert property (@(posedge clk)
        (wr_en == '0) || (wr_en == BYTE_EN_WORD))
        else $error("wr_en %b is neither idle nor a full word", wr_en);

    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    pc_zero_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (pc == '0))
        else $error("pc %h is not zero after reset", pc);

endmodule

bind rv_core rv_core_props u_props (
    .clk   (clk),
    .reset (reset),
    .wr_en (wr_en),
    .pc    (pc)
);

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::instr_t   instr,
    input  rv_pkg::word_t    rd_data,
    output rv_pkg::byte_en_t wr_en,
    output rv_pkg::word_t    pc,
    output rv_pkg::word_t    addr,
    output rv_pkg::word_t    wr_data
);
    import rv_pkg::*;

    alu_op_t  alu_op;
    imm_fmt_t imm_fmt;
    pc_sel_t  pc_sel;
    wb_sel_t  wb_sel;
    logic     src_1_pc;
    logic     src_2_imm;
    logic     rf_wr_en;
    logic     mem_access;
    logic     branch_flag;

    word_t imm;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_in_1;
    word_t alu_in_2;
    word_t alu_result;
    word_t wb_data;
    word_t pc_plus4;
    word_t pc_target;
    word_t pc_next;

    rv_decoder u_decoder (
        .reset       (reset),
        .instr       (instr),
        .branch_flag (branch_flag),
        .alu_op      (alu_op),
        .imm_fmt     (imm_fmt),
        .src_1_pc    (src_1_pc),
        .src_2_imm   (src_2_imm),
        .pc_sel      (pc_sel),
        .wb_sel      (wb_sel),
        .rf_wr_en    (rf_wr_en),
        .wr_en       (wr_en),
        .mem_access  (mem_access)
    );

    rv_imm_gen u_imm_gen (
        .instr (instr),
        .fmt   (imm_fmt),
        .imm   (imm)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .wr_en    (rf_wr_en),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .rd_addr  (instr[11:7]),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Operand selects
    assign alu_in_1 = src_1_pc ? pc : rs1_data;
    assign alu_in_2 = src_2_imm ? imm : rs2_data;

    rv_alu u_alu (
        .op     (alu_op),
        .in_1   (alu_in_1),
        .in_2   (alu_in_2),
        .result (alu_result),
        .flag   (branch_flag)
    );

    assign pc_plus4  = pc + PC_STEP;
    assign pc_target = pc + imm;

    always_comb begin
        case (wb_sel)
            WB_MEM:      wb_data = rd_data;
            WB_PC_PLUS4: wb_data = pc_plus4;
            WB_IMM:      wb_data = imm;
            default:     wb_data = alu_result;
        endcase
    end

    // JALR target has bit 0 cleared
    always_comb begin
        case (pc_sel)
            PC_TARGET:      pc_next = pc_target;
            PC_ALU_ALIGNED: pc_next = {alu_result[XLEN-1:1], 1'b0};
            default:        pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Word-aligned data memory port
    assign addr    = mem_access ? {alu_result[XLEN-1:2], 2'b00} : alu_result;
    assign wr_data = rs2_data;

endmodule

//--- rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic             reset,
    input  rv_pkg::instr_t   instr,
    input  logic             branch_flag,
    output rv_pkg::alu_op_t  alu_op,
    output rv_pkg::imm_fmt_t imm_fmt,
    output logic             src_1_pc,
    output logic             src_2_imm,
    output rv_pkg::pc_sel_t  pc_sel,
    output rv_pkg::wb_sel_t  wb_sel,
    output logic             rf_wr_en,
    output rv_pkg::byte_en_t wr_en,
    output logic             mem_access
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       funct7_zero;
    logic       funct7_alt;
    logic       is_branch;
    pc_sel_t    pc_sel_base;

    assign opcode      = instr[6:0];
    assign funct3      = instr[14:12];
    assign funct7      = instr[31:25];
    assign funct7_zero = (funct7 == 7'b0000000);
    assign funct7_alt  = (funct7 == 7'b0100000);

    // Anything not matched below stays a no-operation
    always_comb begin
        alu_op      = ALU_ADD;
        imm_fmt     = IMM_I;
        src_1_pc    = 1'b0;
        src_2_imm   = 1'b0;
        pc_sel_base = PC_PLUS4;
        wb_sel      = WB_ALU;
        rf_wr_en    = 1'b0;
        wr_en       = '0;
        mem_access  = 1'b0;
        is_branch   = 1'b0;

        if (!reset) begin
            case (opcode)
                LOAD: begin
                    if (funct3 == 3'b010) begin
                        src_2_imm  = 1'b1;
                        wb_sel     = WB_MEM;
                        rf_wr_en   = 1'b1;
                        mem_access = 1'b1;
                    end
                end
                STORE: begin
                    if (funct3 == 3'b010) begin
                        imm_fmt    = IMM_S;
                        src_2_imm  = 1'b1;
                        wr_en      = BYTE_EN_WORD;
                        mem_access = 1'b1;
                    end
                end
                OP_IMM: begin
                    src_2_imm = 1'b1;
                    if (funct3 == 3'b001) begin
                        imm_fmt  = IMM_I_SHAMT;
                        alu_op   = ALU_SLL;
                        rf_wr_en = funct7_zero;
                    end else if (funct3 == 3'b101) begin
                        // Bit 30 picks arithmetic shift only for SRAI
                        imm_fmt  = IMM_I_SHAMT;
                        alu_op   = alu_op_t'({funct7[5], funct3});
                        rf_wr_en = funct7_zero || funct7_alt;
                    end else begin
                        alu_op   = alu_op_t'({1'b0, funct3});
                        rf_wr_en = 1'b1;
                    end
                end
                OP: begin
                    alu_op = alu_op_t'({funct7[5], funct3});
                    // SUB and SRA are the only alternate encodings
                    rf_wr_en = funct7_zero ||
                               (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
                end
                BRANCH: begin
                    imm_fmt = IMM_B;
                    case (funct3[2:1])
                        2'b00: begin
                            alu_op    = ALU_SUB;
                            is_branch = 1'b1;
                        end
                        2'b10: begin
                            alu_op    = ALU_SLT;
                            is_branch = 1'b1;
                        end
                        2'b11: begin
                            alu_op    = ALU_SLTU;
                            is_branch = 1'b1;
                        end
                        default: ;
                    endcase
                end
                JAL: begin
                    imm_fmt     = IMM_J;
                    pc_sel_base = PC_TARGET;
                    wb_sel      = WB_PC_PLUS4;
                    rf_wr_en    = 1'b1;
                end
                JALR: begin
                    if (funct3 == 3'b000) begin
                        src_2_imm   = 1'b1;
                        pc_sel_base = PC_ALU_ALIGNED;
                        wb_sel      = WB_PC_PLUS4;
                        rf_wr_en    = 1'b1;
                    end
                end
                LUI: begin
                    imm_fmt  = IMM_U;
                    wb_sel   = WB_IMM;
                    rf_wr_en = 1'b1;
                end
                AUIPC: begin
                    imm_fmt   = IMM_U;
                    src_1_pc  = 1'b1;
                    src_2_imm = 1'b1;
                    rf_wr_en  = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // funct3[0] selects the negated conditions BNE, BGE and BGEU
    assign pc_sel = (is_branch && (branch_flag ^ funct3[0])) ? PC_TARGET : pc_sel_base;

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rd_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [REG_COUNT];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wr_en && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Combinational reads, x0 forced to zero
    always_comb begin
        rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
        rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    end

endmodule

//--- rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
    input  rv_pkg::instr_t   instr,
    input  rv_pkg::imm_fmt_t fmt,
    output rv_pkg::word_t    imm
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            IMM_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            // Shift amount is zero-filled
            IMM_I_SHAMT: begin
                imm = {27'b0, instr[24:20]};
            end
            IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   in_1,
    input  rv_pkg::word_t   in_2,
    output rv_pkg::word_t   result,
    output logic            flag
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = in_2[4:0];

    always_comb begin
        flag = 1'b0;
        case (op)
            ALU_ADD:  result = in_1 + in_2;
            ALU_SUB: begin
                result = in_1 - in_2;
                // Equality test for BEQ and BNE
                flag   = (result == '0);
            end
            ALU_SLL:  result = in_1 << shamt;
            ALU_SLT: begin
                result = word_t'($signed(in_1) < $signed(in_2));
                flag   = result[0];
            end
            ALU_SLTU: begin
                result = word_t'(in_1 < in_2);
                flag   = result[0];
            end
            ALU_XOR:  result = in_1 ^ in_2;
            ALU_SRL:  result = in_1 >> shamt;
            ALU_SRA:  result = word_t'($signed(in_1) >>> shamt);
            ALU_OR:   result = in_1 | in_2;
            ALU_AND:  result = in_1 & in_2;
            default:  result = '0;
        endcase
    end

endmodule

//--- rv_pkg.sv
package rv_pkg;

    // Machine widths
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
    typedef logic [31:0]                  instr_t;
    typedef logic [XLEN/8-1:0]            byte_en_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_t;

    // Top bit is funct7[5], low bits are funct3
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_I_SHAMT,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_fmt_t;

    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_TARGET,
        PC_ALU_ALIGNED
    } pc_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4,
        WB_IMM
    } wb_sel_t;

    localparam byte_en_t BYTE_EN_WORD = '1;
    localparam word_t    PC_STEP      = 32'd4;

endpackage
